//--- sim.f
logic/reb_pkg.sv
logic/reb_if.sv
logic/reb_store.sv
logic/exec_sched.sv
logic/retire_sched.sv
logic/reb_top.sv
sim/tb_clkgen.sv
sim/tb_checker.sv
sim/tb_reb.sv

//--- sim/tb_reb.sv
// Reorder buffer testbench top
// Clock, DUT, checker, stimulus tasks, execution unit and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_reb
	import reb_pkg::*;
();

	// Instructions over all tests, the timeout scales with them
	localparam int N_TOTAL = 12 + 12 + 4 + 7 + 60;
	localparam int LIMIT = 60 * N_TOTAL + 200;

	logic clk;
	logic rst_n;
	logic alloc_req;
	logic [TAG_W-1:0] alloc_tag;
	logic alloc_mem;
	logic alloc_rdy;
	logic alloc_ack;
	logic wake_valid;
	logic [TAG_W-1:0] wake_tag;
	logic exec_req;
	logic [TAG_W-1:0] exec_tag;
	logic exec_ack;
	logic retire0_valid;
	logic [TAG_W-1:0] retire0_tag;
	logic retire1_valid;
	logic [TAG_W-1:0] retire1_tag;
	// Holds the execution unit off
	logic stall = 1'b0;
	logic done_sending;
	logic [TAG_W-1:0] next_tag = 8'd1;
	logic [TAG_W-1:0] sleepers [$];
	int sent = 0;
	int n_bad = 0;
	int cycles = 0;

	tb_clkgen u_clk (.clk(clk), .rst_n(rst_n));
	reb_top DUT (.*);
	tb_checker u_chk (.*);

	// Four-phase allocate of one instruction
	task automatic send_instr(input logic mem, input logic rdy, output logic [TAG_W-1:0] tag);
		tag = next_tag;
		next_tag++;
		@(negedge clk);
		alloc_req = 1'b1;
		alloc_tag = tag;
		alloc_mem = mem;
		alloc_rdy = rdy;
		do @(negedge clk); while (!alloc_ack);
		alloc_req = 1'b0;
		do @(negedge clk); while (alloc_ack);
		sent++;
	endtask

	task automatic pulse_wake(input logic [TAG_W-1:0] tag);
		@(negedge clk);
		wake_valid = 1'b1;
		wake_tag = tag;
		@(negedge clk);
		wake_valid = 1'b0;
	endtask

	// Drain, then one line per test
	task automatic end_test(input int idx, input string name, input int err0);
		while (u_chk.n_retired != sent)
			@(negedge clk);
		if (u_chk.errors != err0)
			n_bad++;
		$display("test %0d %s: %s", idx, name, (u_chk.errors == err0) ? "ok" : "FAIL");
	endtask

	// Execution unit, acks 1 to 4 cycles after the request
	initial begin
		exec_ack = 1'b0;
		forever begin
			@(negedge clk);
			if (exec_req && !stall) begin
				repeat ($urandom_range(4, 1) - 1)
					@(negedge clk);
				exec_ack = 1'b1;
				do @(negedge clk); while (exec_req);
				exec_ack = 1'b0;
			end
		end
	end

	// ====================
	// Tests
	// ====================
	initial begin
		logic [TAG_W-1:0] t;
		logic [TAG_W-1:0] w;
		logic [TAG_W-1:0] held [6];
		logic [31:0] r;
		int seed;
		int e0;
		int idx;
		seed = $urandom(35);
		alloc_req = 1'b0;
		alloc_tag = '0;
		alloc_mem = 1'b0;
		alloc_rdy = 1'b0;
		wake_valid = 1'b0;
		wake_tag = '0;
		wait (rst_n === 1'b1);

		e0 = u_chk.errors;
		for (int i = 0; i < 12; i++)
			send_instr(1'b0, 1'b1, t);
		end_test(1, "in-order retire", e0);

		// Older memory ops held not ready, younger ready ones must wait behind them
		e0 = u_chk.errors;
		for (int g = 0; g < 2; g++) begin
			for (int i = 0; i < 6; i++) begin
				send_instr(i % 3 != 1, i % 3 != 0, t);
				held[i] = t;
			end
			repeat (10) @(negedge clk);
			for (int i = 0; i < 6; i += 3)
				pulse_wake(held[i]);
		end
		end_test(2, "memory order", e0);

		// Not ready until woken, youngest woken first
		e0 = u_chk.errors;
		for (int i = 0; i < 4; i++) begin
			send_instr(i % 2 == 0, 1'b0, t);
			held[i] = t;
		end
		repeat (20) @(negedge clk);
		for (int i = 3; i >= 0; i--)
			pulse_wake(held[i]);
		end_test(3, "wake", e0);

		// Seventh waits on a full buffer until the unit resumes
		e0 = u_chk.errors;
		stall = 1'b1;
		for (int i = 0; i < 6; i++)
			send_instr(1'b0, 1'b1, t);
		fork
			send_instr(1'b0, 1'b1, t);
			begin
				repeat (12) @(negedge clk);
				stall = 1'b0;
			end
		join
		end_test(4, "full buffer", e0);

		e0 = u_chk.errors;
		done_sending = 1'b0;
		fork
			begin
				for (int i = 0; i < 60; i++) begin
					r = $urandom;
					send_instr(r[0], r[1] | r[2], t);
					if (!(r[1] | r[2]))
						sleepers.push_back(t);
				end
				done_sending = 1'b1;
			end
			// Wakes sleeping tags in random order
			begin
				while (!done_sending || sleepers.size() > 0) begin
					repeat ($urandom_range(6, 1)) @(negedge clk);
					if (sleepers.size() > 0) begin
						idx = $urandom_range(sleepers.size() - 1, 0);
						w = sleepers[idx];
						sleepers.delete(idx);
						pulse_wake(w);
					end
				end
			end
		join
		end_test(5, "random", e0);

		$display("%0d of 5 tests ok, %0d errors", 5 - n_bad, u_chk.errors);
		if (u_chk.errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial begin
		while (cycles < LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, a handshake never completed", LIMIT);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/tb_checker.sv
// Reorder buffer reference model kept in program order
// Expected-issue function, compare process, error and retire counts
`timescale 1ns/1ps
`default_nettype none

module tb_checker
	import reb_pkg::*;
(
	input logic             clk,
	input logic             rst_n,
	input logic             alloc_ack,
	input logic [TAG_W-1:0] alloc_tag,
	input logic             alloc_mem,
	input logic             alloc_rdy,
	input logic             wake_valid,
	input logic [TAG_W-1:0] wake_tag,
	input logic             exec_req,
	input logic [TAG_W-1:0] exec_tag,
	input logic             exec_ack,
	input logic             retire0_valid,
	input logic [TAG_W-1:0] retire0_tag,
	input logic             retire1_valid,
	input logic [TAG_W-1:0] retire1_tag
);

	// Oldest first, sn field unused
	reb_entry_t q [$];
	reb_entry_t e;
	logic [TAG_W-1:0] open_tag;
	logic [TAG_W:0] exp_t;
	// Outputs as seen on the previous falling edge
	logic req_q;
	logic ack_q;
	// Inputs as the DUT saw them on the last rising edge
	logic wake_s;
	logic [TAG_W-1:0] wtag_s;
	logic xack_s;
	logic [TAG_W-1:0] atag_s;
	logic mem_s;
	logic rdy_s;
	int occ;
	int errors = 0;
	int n_retired = 0;

	// Oldest ready unissued entry, memory ops wait behind older memory ops
	function automatic logic [TAG_W:0] fn_expected_exec();
		reb_entry_t x;
		logic mem_wait;
		mem_wait = 1'b0;
		for (int i = 0; i < q.size(); i++) begin
			x = q[i];
			if (!x.issued && x.rdy && !(x.mem && mem_wait))
				return {1'b1, x.tag};
			if (x.mem && !x.issued)
				mem_wait = 1'b1;
		end
		return '0;
	endfunction

	// Flag 0 issued, 1 executed, else operands ready
	task automatic set_flag(input logic [TAG_W-1:0] tag, input int which);
		reb_entry_t x;
		for (int i = 0; i < q.size(); i++) begin
			x = q[i];
			if (x.tag == tag) begin
				case (which)
					0: x.issued = 1'b1;
					1: x.executed = 1'b1;
					default: x.rdy = 1'b1;
				endcase
				q[i] = x;
			end
		end
	endtask

	task automatic report_mismatch(input string msg);
		$display("MISMATCH at %0t ns: %s", $time, msg);
		errors++;
	endtask

	always @(posedge clk) begin
		wake_s <= wake_valid;
		wtag_s <= wake_tag;
		xack_s <= exec_ack;
		atag_s <= alloc_tag;
		mem_s <= alloc_mem;
		rdy_s <= alloc_rdy;
	end

	// ====================
	// Compare on falling edges
	// ====================
	always @(negedge clk) begin
		if (!rst_n) begin
			q.delete();
			req_q = 1'b0;
			ack_q = 1'b0;
		end else begin
			occ = q.size();
			exp_t = fn_expected_exec();
			// Issue is decided from the state before the edge
			if (exec_req && !req_q) begin
				if (!exp_t[TAG_W])
					report_mismatch($sformatf("tag %0h issued, none eligible", exec_tag));
				else if (exec_tag != exp_t[TAG_W-1:0])
					report_mismatch($sformatf("issued tag %0h, expected %0h",
						exec_tag, exp_t[TAG_W-1:0]));
				set_flag(exec_tag, 0);
				open_tag = exec_tag;
			end else if (!req_q && !xack_s && exp_t[TAG_W]) begin
				report_mismatch($sformatf("no issue, expected tag %0h", exp_t[TAG_W-1:0]));
			end
			// Up to two retirements from the head, retire0 first
			for (int k = 0; k < 2; k++) begin
				logic got;
				logic [TAG_W-1:0] rtag;
				got = (k == 0) ? retire0_valid : retire1_valid;
				rtag = (k == 0) ? retire0_tag : retire1_tag;
				e = (q.size() > 0) ? q[0] : '0;
				if (got != (e.executed && (k == 0 || retire0_valid)))
					report_mismatch($sformatf("retire%0d valid %b, head %0h executed %b",
						k, got, e.tag, e.executed));
				else if (got && rtag != e.tag)
					report_mismatch($sformatf("retire%0d tag %0h, expected %0h", k, rtag, e.tag));
				if (got && q.size() > 0) begin
					e = q.pop_front();
					n_retired++;
				end
			end
			if (wake_s)
				set_flag(wtag_s, 2);
			// Request closed on this edge
			if (!exec_req && req_q)
				set_flag(open_tag, 1);
			if (alloc_ack && !ack_q) begin
				if (occ >= REB_ENTRIES) begin
					$display("ERROR at %0t ns: allocation accepted with all slots taken", $time);
					errors++;
				end
				e = '{v: 1'b1, mem: mem_s, rdy: rdy_s, issued: 1'b0, executed: 1'b0,
					sn: '0, tag: atag_s};
				q.push_back(e);
			end
			req_q = exec_req;
			ack_q = alloc_ack;
		end
	end

endmodule

`default_nettype wire

//--- sim/tb_clkgen.sv
// Testbench clock and reset
// 100 ns period, reset held low for three cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Release on a falling edge after three rising edges
	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- logic/reb_top.sv
// Reorder buffer top level
// Store plus execute and retire schedulers on a shared interface
`timescale 1ns/1ps
`default_nettype none

module reb_top
	import reb_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	// Allocate, four-phase
	input  logic             alloc_req,
	input  logic [TAG_W-1:0] alloc_tag,
	input  logic             alloc_mem,
	input  logic             alloc_rdy,
	output logic             alloc_ack,
	// Operand wake
	input  logic             wake_valid,
	input  logic [TAG_W-1:0] wake_tag,
	// Execution unit, four-phase
	output logic             exec_req,
	output logic [TAG_W-1:0] exec_tag,
	input  logic             exec_ack,
	// Retire, up to two per cycle
	output logic             retire0_valid,
	output logic [TAG_W-1:0] retire0_tag,
	output logic             retire1_valid,
	output logic [TAG_W-1:0] retire1_tag
);

	reb_if rb (.clk(clk), .rst_n(rst_n));

	reb_store u_store (.*, .rb(rb.store));

	exec_sched u_exec_sched (.rb(rb.exec_sched));

	retire_sched u_retire_sched (.rb(rb.retire_sched));

endmodule

`default_nettype wire

//--- logic/retire_sched.sv
// Retire scheduler
// Picks up to two executed slots at the head of program order
`timescale 1ns/1ps
`default_nettype none

module retire_sched
	import reb_pkg::*;
(
	reb_if.retire_sched rb
);

	logic [SLOT_W-1:0] pick0;
	logic [SLOT_W-1:0] pick1;
	// Sequence number right behind the head
	logic [SN_W-1:0] next_sn;

	assign next_sn = rb.head_sn + 1'b1;

	// ====================
	// Head and head plus one
	// ====================
	always_comb begin
		pick0 = SLOT_NONE;
		for (int i = 0; i < REB_ENTRIES; i++) begin
			if (rb.ent[i].v && rb.ent[i].executed && rb.ent[i].sn == rb.head_sn)
				pick0 = SLOT_W'(i);
		end
	end

	// Second slot only behind a retiring head
	always_comb begin
		pick1 = SLOT_NONE;
		for (int i = 0; i < REB_ENTRIES; i++) begin
			if (pick0 != SLOT_NONE && rb.ent[i].v && rb.ent[i].executed &&
				rb.ent[i].sn == next_sn)
				pick1 = SLOT_W'(i);
		end
	end

	assign rb.retire_pick0 = pick0;
	assign rb.retire_pick1 = pick1;

	a_in_order: assert property (@(posedge rb.clk) disable iff (!rb.rst_n)
		(rb.retire_pick0 == SLOT_NONE) |-> (rb.retire_pick1 == SLOT_NONE))
		else $error("second retire pick without a first");

endmodule

`default_nettype wire

//--- logic/exec_sched.sv
// Execute scheduler
// Picks the oldest ready, unissued slot
// Memory slots issue strictly in program order
`timescale 1ns/1ps
`default_nettype none

module exec_sched
	import reb_pkg::*;
(
	reb_if.exec_sched rb
);

	// Slot has an older memory op still waiting
	logic [REB_ENTRIES-1:0] mem_block;
	logic [REB_ENTRIES-1:0] elig;
	logic [SLOT_W-1:0] best;
	logic [SN_W-1:0] best_age;

	// ====================
	// Eligibility
	// ====================
	always_comb begin
		for (int i = 0; i < REB_ENTRIES; i++) begin
			mem_block[i] = 1'b0;
			for (int j = 0; j < REB_ENTRIES; j++) begin
				// Any older live memory op not yet sent blocks a memory op
				if (rb.ent[j].v && rb.ent[j].mem && !rb.ent[j].issued &&
					fn_age(rb.ent[j].sn, rb.head_sn) < fn_age(rb.ent[i].sn, rb.head_sn))
					mem_block[i] = 1'b1;
			end
			elig[i] = rb.ent[i].v && !rb.ent[i].issued && rb.ent[i].rdy &&
				!(rb.ent[i].mem && mem_block[i]);
		end
	end

	// ====================
	// Oldest eligible wins
	// ====================
	always_comb begin
		best = SLOT_NONE;
		best_age = '1;
		for (int i = 0; i < REB_ENTRIES; i++) begin
			if (elig[i] && (best == SLOT_NONE ||
				fn_age(rb.ent[i].sn, rb.head_sn) < best_age)) begin
				best = SLOT_W'(i);
				best_age = fn_age(rb.ent[i].sn, rb.head_sn);
			end
		end
	end

	assign rb.exec_pick = best;

	// Pick must name a live slot the store can issue
	a_pick_valid: assert property (@(posedge rb.clk) disable iff (!rb.rst_n)
		(rb.exec_pick == SLOT_NONE) ||
		(rb.exec_pick < REB_ENTRIES && rb.ent[rb.exec_pick].v))
		else $error("execute pick names an empty slot");

endmodule

`default_nettype wire

//--- logic/reb_store.sv
// Reorder buffer slot storage
// Allocate handshake, wake, execute handshake and retirement
// Checks on the execute handshake and on retired slots
`timescale 1ns/1ps
`default_nettype none

module reb_store
	import reb_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             alloc_req,
	input  logic [TAG_W-1:0] alloc_tag,
	input  logic             alloc_mem,
	input  logic             alloc_rdy,
	output logic             alloc_ack,
	input  logic             wake_valid,
	input  logic [TAG_W-1:0] wake_tag,
	output logic             exec_req,
	output logic [TAG_W-1:0] exec_tag,
	input  logic             exec_ack,
	output logic             retire0_valid,
	output logic [TAG_W-1:0] retire0_tag,
	output logic             retire1_valid,
	output logic [TAG_W-1:0] retire1_tag,
	reb_if.store             rb
);

	reb_entry_t ent [REB_ENTRIES];
	logic [SN_W-1:0] head_sn;
	logic [SN_W-1:0] next_sn;
	// Slot of the open execute request
	logic [SLOT_W-1:0] exec_slot;
	logic [SLOT_W-1:0] free_slot;
	logic alloc_go;
	logic issue_go;
	logic ret0_go;
	logic ret1_go;

	assign rb.ent = ent;
	assign rb.head_sn = head_sn;

	// Lowest free slot, scanning down so slot 0 wins
	always_comb begin
		free_slot = SLOT_NONE;
		for (int i = REB_ENTRIES - 1; i >= 0; i--) begin
			if (!ent[i].v)
				free_slot = SLOT_W'(i);
		end
	end

	assign alloc_go = alloc_req && !alloc_ack && (free_slot != SLOT_NONE);
	// New request only with no request open and ack seen low
	assign issue_go = !exec_req && !exec_ack && (rb.exec_pick != SLOT_NONE);
	assign ret0_go = rb.retire_pick0 != SLOT_NONE;
	assign ret1_go = rb.retire_pick1 != SLOT_NONE;

	// ====================
	// Control state
	// ====================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < REB_ENTRIES; i++)
				ent[i] <= '0;
			head_sn <= '0;
			next_sn <= '0;
			exec_slot <= SLOT_NONE;
			alloc_ack <= 1'b0;
			exec_req <= 1'b0;
			retire0_valid <= 1'b0;
			retire1_valid <= 1'b0;
		end else begin
			// Wake marks every matching live slot
			for (int i = 0; i < REB_ENTRIES; i++) begin
				if (wake_valid && ent[i].v && ent[i].tag == wake_tag)
					ent[i].rdy <= 1'b1;
			end
			// Issue the scheduler's pick
			if (issue_go) begin
				ent[rb.exec_pick].issued <= 1'b1;
				exec_slot <= rb.exec_pick;
				exec_req <= 1'b1;
			end
			// Completion closes the request
			if (exec_req && exec_ack) begin
				ent[exec_slot].executed <= 1'b1;
				exec_req <= 1'b0;
			end
			// Retire in order, pick0 then pick1
			retire0_valid <= ret0_go;
			retire1_valid <= ret1_go;
			if (ret0_go)
				ent[rb.retire_pick0] <= '0;
			if (ret1_go)
				ent[rb.retire_pick1] <= '0;
			head_sn <= head_sn + SN_W'(ret0_go) + SN_W'(ret1_go);
			// Allocate handshake, ack drops once req is seen low
			if (alloc_go) begin
				ent[free_slot] <= '{v: 1'b1, mem: alloc_mem, rdy: alloc_rdy,
					issued: 1'b0, executed: 1'b0, sn: next_sn, tag: alloc_tag};
				next_sn <= next_sn + 1'b1;
				alloc_ack <= 1'b1;
			end else if (alloc_ack && !alloc_req) begin
				alloc_ack <= 1'b0;
			end
		end
	end

	// Tags captured alongside the control edges
	always_ff @(posedge clk) begin
		if (issue_go)
			exec_tag <= ent[rb.exec_pick].tag;
		if (ret0_go)
			retire0_tag <= ent[rb.retire_pick0].tag;
		if (ret1_go)
			retire1_tag <= ent[rb.retire_pick1].tag;
	end

	// ====================
	// Checks
	// ====================
	a_req_after_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
		(!exec_req && exec_ack) |=> !exec_req)
		else $error("exec_req rose while exec_ack high");

	a_retire_executed: assert property (@(posedge clk) disable iff (!rst_n)
		ret0_go |-> ent[rb.retire_pick0].v && ent[rb.retire_pick0].executed &&
		(!ret1_go || (ent[rb.retire_pick1].v && ent[rb.retire_pick1].executed)))
		else $error("retiring a slot that has not executed");

endmodule

`default_nettype wire

//--- logic/reb_if.sv
// Buffer state shared between store and schedulers
// Carries the slot array, head sequence number and the three picks
// One modport per module
`timescale 1ns/1ps
`default_nettype none

interface reb_if
	import reb_pkg::*;
(
	input logic clk,
	input logic rst_n
);

	// Slot state, owned by the store
	reb_entry_t ent [REB_ENTRIES];
	// Sequence number of the next instruction to retire
	logic [SN_W-1:0] head_sn;

	// Scheduler picks, combinational from register state
	logic [SLOT_W-1:0] exec_pick;
	logic [SLOT_W-1:0] retire_pick0;
	logic [SLOT_W-1:0] retire_pick1;

	// Store owns state and consumes every pick
	modport store (output ent, output head_sn,
		input exec_pick, input retire_pick0, input retire_pick1);

	// Clock only feeds the scheduler checks
	modport exec_sched (input clk, input rst_n, input ent, input head_sn,
		output exec_pick);

	modport retire_sched (input clk, input rst_n, input ent, input head_sn,
		output retire_pick0, output retire_pick1);

endinterface

`default_nettype wire

//--- logic/reb_pkg.sv
// Reorder buffer sizes and field widths
// Slot entry struct
// Age helper used by both schedulers
`default_nettype none

package reb_pkg;

	// ====================
	// Sizes and widths
	// ====================
	localparam int REB_ENTRIES = 6;
	localparam int SLOT_W = 3;
	// Slot code 7 marks an empty pick
	localparam logic [SLOT_W-1:0] SLOT_NONE = 3'd7;
	// Wraps mod 16, never more than 6 in flight
	localparam int SN_W = 4;
	localparam int TAG_W = 8;

	// One buffer slot
	typedef struct packed {
		logic v;
		logic mem;
		logic rdy;
		logic issued;
		logic executed;
		logic [SN_W-1:0] sn;
		logic [TAG_W-1:0] tag;
	} reb_entry_t;

	// Distance from the head, smaller is older
	function automatic logic [SN_W-1:0] fn_age(input logic [SN_W-1:0] sn,
		input logic [SN_W-1:0] head);
		return sn - head;
	endfunction

endpackage

`default_nettype wire
